// ==== src.f ====
+incdir+verilog
verilog/tmr_pkg.sv
verilog/copy_bus_if.sv
verilog/copy_capture.sv
verilog/copy_buffer.sv
verilog/vote_sender.sv
verilog/tmr_receiver.sv
sim/tb_tmr_receiver.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_tmr_receiver

.PHONY: run clean

run: $(SIM)
	./$(SIM)

# rebuilt only when a listed source, the header or the list itself changes
$(SIM): src.f $(shell grep -v '^+' src.f) verilog/tmr_params.svh
	verilator --binary -j 0 --timescale 1ns/1ns --top-module tb_tmr_receiver \
		-Mdir obj_dir -f src.f

clean:
	rm -rf obj_dir

// ==== sim/tb_tmr_receiver.sv ====
`timescale 1ns/1ns
`include "tmr_params.svh"

module tb_tmr_receiver;

	localparam int CLK_PERIOD = 20;
	localparam int GAP        = 2;                  // idle cycles after each frame
	localparam int WINDOW     = `TMR_MAX_LEN + 16;  // longest compare plus slack
	localparam int MARGIN     = 2000;

	logic                   clk;
	logic                   arst_n;
	logic                   rx_en;
	logic [`TMR_DATA_W-1:0] rx_data;
	logic [`TMR_DATA_W-1:0] data_out;
	logic                   en_out;
	logic                   lost;

	logic [`TMR_DATA_W-1:0] frame_buf [`TMR_MAX_LEN];  // payload of the next frame
	logic [`TMR_DATA_W-1:0] base_buf  [`TMR_MAX_LEN];
	logic [`TMR_DATA_W-1:0] pay       [3][`TMR_MAX_LEN];  // copies kept for the model
	int                     pay_len   [3];
	bit                     pay_in    [3];
	logic [`TMR_DATA_W-1:0] exp_bytes [`TMR_MAX_LEN];
	int                     exp_len;
	logic                   exp_lost;
	logic [`TMR_DATA_W-1:0] got_q [$];
	int                     lost_cnt;
	int                     budget;                  // cycles the watchdog allows

	tmr_receiver tmr_receiver_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.rx_en    (rx_en),
		.rx_data  (rx_data),
		.data_out (data_out),
		.en_out   (en_out),
		.lost     (lost)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// output monitor, mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (arst_n) begin
			if (en_out)
				got_q.push_back(data_out);
			if (lost)
				lost_cnt++;
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > budget + MARGIN) begin
				$display("Simulation failed");
				$fatal(1, "watchdog: the run took longer than its frames allow");
			end
		end
	end

	// ========================================================================
	// compare tasks
	// ========================================================================
	task automatic check_byte(input string name, input logic [`TMR_DATA_W-1:0] exp,
		input logic [`TMR_DATA_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %02h, actual %02h", name, exp, act);
			$display("Simulation failed");
			$fatal(1, "output byte mismatch");
		end
	endtask

	task automatic check_len(input string name, input logic [`TMR_LEN_W-1:0] exp,
		input logic [`TMR_LEN_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %0d bytes, actual %0d bytes", name, exp, act);
			$display("Simulation failed");
			$fatal(1, "output length mismatch");
		end
	endtask

	task automatic check_lost(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected lost %0b, actual lost %0b", name, exp, act);
			$display("Simulation failed");
			$fatal(1, "lost flag mismatch");
		end
	endtask

	// ========================================================================
	// reference model
	// ========================================================================
	function automatic bit agree(input int a, input int b);
		if (!pay_in[a] || !pay_in[b] || pay_len[a] != pay_len[b])
			return 1'b0;
		for (int i = 0; i < pay_len[a]; i++)
			if (pay[a][i] !== pay[b][i])
				return 1'b0;
		return 1'b1;
	endfunction

	function automatic void predict_output();
		bit a12;
		bit a13;
		bit a23;
		int sel;
		int n_in;
		a12  = agree(0, 1);
		a13  = agree(0, 2);
		a23  = agree(1, 2);
		n_in = int'(pay_in[0]) + int'(pay_in[1]) + int'(pay_in[2]);
		sel  = -1;  // nothing trusted
		if (a12 || a13)
			sel = 0;
		else if (a23)
			sel = 1;
		else if (n_in == 1)
			sel = pay_in[0] ? 0 : (pay_in[1] ? 1 : 2);
		exp_lost = !(a12 && a13 && a23);
		exp_len  = (sel < 0) ? 0 : pay_len[sel];
		for (int i = 0; i < exp_len; i++)
			exp_bytes[i] = pay[sel][i];
	endfunction

	// ========================================================================
	// stimulus helpers
	// ========================================================================
	task automatic clear_group();
		for (int c = 0; c < 3; c++) begin
			pay_in[c]  = 1'b0;
			pay_len[c] = 0;
		end
		got_q.delete();
		lost_cnt = 0;
	endtask

	task automatic make_payload(input int len);
		for (int i = 0; i < len; i++)
			frame_buf[i] = 8'($urandom);
	endtask

	task automatic flip_byte(input int pos);
		frame_buf[pos] = frame_buf[pos] ^ 8'($urandom_range(255, 1));
	endtask

	task automatic keep_copy(input int c, input int len);
		for (int i = 0; i < len; i++)
			pay[c - 1][i] = frame_buf[i];
		pay_len[c - 1] = len;
		pay_in[c - 1]  = 1'b1;
	endtask

	task automatic send_frame(input logic [3:0] copy_num, input int len);
		for (int i = 0; i < `TMR_ID_OFFSET; i++) begin
			@(posedge clk);
			rx_en   <= 1'b1;
			rx_data <= 8'($urandom);  // header bytes carry nothing
		end
		@(posedge clk);
		rx_en   <= 1'b1;
		rx_data <= {4'($urandom), copy_num};
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			rx_data <= frame_buf[i];
		end
		@(posedge clk);
		rx_en   <= 1'b0;
		rx_data <= '0;
		repeat (GAP) @(posedge clk);
		budget += 3 * (len + `TMR_ID_OFFSET + 1 + GAP);
	endtask

	task automatic full_group(input int len);
		make_payload(len);
		for (int c = 1; c <= 3; c++) begin
			keep_copy(c, len);
			send_frame(4'(c), len);
		end
	endtask

	// waits for en_out to fall, or a quiet window when nothing comes
	task automatic collect(input int exp_n);
		int  idle;
		bit  seen;
		idle   = 0;
		seen   = 1'b0;
		budget += WINDOW + exp_n;
		while (idle < WINDOW) begin
			@(negedge clk);
			if (en_out)
				seen = 1'b1;
			else if (seen)
				break;
			else
				idle++;
		end
		@(posedge clk);
	endtask

	task automatic wait_output();
		int n;
		n = 0;
		while (!en_out && n < WINDOW) begin
			@(negedge clk);
			n++;
		end
		if (!en_out) begin
			$display("en_out never rose for the group that should be streaming");
			$display("Simulation failed");
			$fatal(1, "no output stream");
		end
	endtask

	task automatic verify_group(input string name);
		int got_n;
		predict_output();
		collect(exp_len);
		got_n = got_q.size();
		check_len(name, exp_len[`TMR_LEN_W-1:0], got_n[`TMR_LEN_W-1:0]);
		for (int i = 0; i < exp_len; i++)
			check_byte($sformatf("%s byte %0d", name, i), exp_bytes[i], got_q[i]);
		check_lost(name, exp_lost, lost_cnt != 0);
		if (lost_cnt > 1) begin
			$display("%s: lost pulsed %0d times for one group", name, lost_cnt);
			$display("Simulation failed");
			$fatal(1, "repeated lost pulse");
		end
		clear_group();
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================
	task automatic all_agree_group();
		full_group(16);
		verify_group("all agree");
		full_group(0);
		verify_group("all agree empty");
		full_group(`TMR_MAX_LEN);
		verify_group("all agree max length");
	endtask

	task automatic one_bad_copy();
		for (int bad = 1; bad <= 3; bad++) begin
			make_payload(12);
			base_buf = frame_buf;
			for (int c = 1; c <= 3; c++) begin
				frame_buf = base_buf;
				if (c == bad)
					flip_byte($urandom_range(11));
				keep_copy(c, 12);
				send_frame(4'(c), 12);
			end
			verify_group($sformatf("copy %0d outvoted", bad));
		end
	endtask

	task automatic close_by_repeat();
		make_payload(10);
		keep_copy(1, 10);
		send_frame(4'd1, 10);
		keep_copy(2, 10);
		send_frame(4'd2, 10);
		send_frame(4'd1, 0);  // closes the group, not stored
		verify_group("copies 1 and 2");
		full_group(8);
		verify_group("full group after close");
	endtask

	task automatic no_majority();
		make_payload(14);
		base_buf = frame_buf;
		keep_copy(1, 14);
		send_frame(4'd1, 14);
		flip_byte(0);
		keep_copy(2, 14);
		send_frame(4'd2, 14);
		frame_buf = base_buf;
		flip_byte(1);
		keep_copy(3, 14);
		send_frame(4'd3, 14);
		verify_group("three different");

		make_payload(9);
		keep_copy(1, 9);
		send_frame(4'd1, 9);
		flip_byte($urandom_range(8));
		keep_copy(3, 9);
		send_frame(4'd3, 9);
		verify_group("pair same length");

		make_payload(10);
		keep_copy(1, 9);
		send_frame(4'd1, 9);
		keep_copy(3, 10);  // same prefix, one byte longer
		send_frame(4'd3, 10);
		verify_group("pair length differs");
	endtask

	task automatic lone_copy();
		make_payload(7);
		keep_copy(2, 7);
		send_frame(4'd2, 7);
		send_frame(4'd1, 0);
		verify_group("single copy 2");
	endtask

	task automatic ignored_frames();
		make_payload(11);
		keep_copy(1, 11);
		send_frame(4'd1, 11);
		send_frame(4'd0, 5);
		send_frame(4'd5, 5);
		keep_copy(2, 11);
		send_frame(4'd2, 11);
		keep_copy(3, 11);
		send_frame(4'd3, 11);
		verify_group("invalid copy numbers");

		full_group(40);
		wait_output();
		send_frame(4'd1, 6);  // both arrive while busy
		send_frame(4'd3, 6);
		verify_group("frames while streaming");
		full_group(5);
		verify_group("group after streaming");
	endtask

	initial begin
		void'($urandom(32'h30db_ca3d));
		clk      = 1'b0;
		arst_n   = 1'b0;
		rx_en    = 1'b0;
		rx_data  = '0;
		budget   = 0;
		clear_group();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		all_agree_group();
		one_bad_copy();
		close_by_repeat();
		no_majority();
		lone_copy();
		ignored_frames();

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== verilog/tmr_receiver.sv ====
`timescale 1ns/1ns
`include "tmr_params.svh"

module tmr_receiver (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   rx_en,
	input  logic [`TMR_DATA_W-1:0] rx_data,
	output logic [`TMR_DATA_W-1:0] data_out,
	output logic                   en_out,
	output logic                   lost
);

	logic                   group_close;
	tmr_pkg::group_rpt_t    group_rpt;
	logic                   busy;
	logic [`TMR_ADDR_W-1:0] rd_addr;
	logic [`TMR_DATA_W-1:0] rd_data1;
	logic [`TMR_DATA_W-1:0] rd_data2;
	logic [`TMR_DATA_W-1:0] rd_data3;

	copy_bus_if wr_bus ();  // capture to buffer writes

	copy_capture capture_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.rx_en       (rx_en),
		.rx_data     (rx_data),
		.busy        (busy),
		.wr          (wr_bus.capture),
		.group_close (group_close),
		.group_rpt   (group_rpt)
	);

	copy_buffer buffer_i (
		.clk      (clk),
		.wr       (wr_bus.buffer),
		.rd_addr  (rd_addr),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.rd_data3 (rd_data3)
	);

	vote_sender vote_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.group_close (group_close),
		.group_rpt   (group_rpt),
		.busy        (busy),
		.rd_addr     (rd_addr),
		.rd_data1    (rd_data1),
		.rd_data2    (rd_data2),
		.rd_data3    (rd_data3),
		.data_out    (data_out),
		.en_out      (en_out),
		.lost        (lost)
	);

endmodule

// ==== verilog/vote_sender.sv ====
`timescale 1ns/1ns
`include "tmr_params.svh"

module vote_sender (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   group_close,
	input  tmr_pkg::group_rpt_t    group_rpt,
	output logic                   busy,
	output logic [`TMR_ADDR_W-1:0] rd_addr,
	input  logic [`TMR_DATA_W-1:0] rd_data1,
	input  logic [`TMR_DATA_W-1:0] rd_data2,
	input  logic [`TMR_DATA_W-1:0] rd_data3,
	output logic [`TMR_DATA_W-1:0] data_out,
	output logic                   en_out,
	output logic                   lost
);

	tmr_pkg::vote_state_e  state;
	tmr_pkg::group_rpt_t   rpt_q;
	tmr_pkg::verdict_e     verdict;
	tmr_pkg::copy_id_e     sel;
	tmr_pkg::copy_id_e     sel_next;
	logic [`TMR_LEN_W-1:0] max_len;
	logic [`TMR_LEN_W-1:0] max_next;
	logic [`TMR_LEN_W-1:0] send_len;
	logic [`TMR_LEN_W-1:0] sel_len;
	logic [`TMR_LEN_W-1:0] cnt;       // address sweep in compare and send
	logic [`TMR_LEN_W-1:0] cmp_addr;  // address of the data now on rd_data
	logic                  in1, in2, in3;
	logic                  mm12, mm13, mm23;
	logic                  a12, a13, a23;
	logic                  start;

	assign start = (state == tmr_pkg::VS_IDLE) && group_close;

	// longest present copy sets the compare sweep
	always_comb begin
		max_next = '0;
		if (group_rpt.present[0] && group_rpt.len1 > max_next)
			max_next = group_rpt.len1;
		if (group_rpt.present[1] && group_rpt.len2 > max_next)
			max_next = group_rpt.len2;
		if (group_rpt.present[2] && group_rpt.len3 > max_next)
			max_next = group_rpt.len3;
	end

	// group report held while the controller runs
	always_ff @(posedge clk) begin
		if (start) begin
			rpt_q   <= group_rpt;
			max_len <= max_next;
		end
		if (state == tmr_pkg::VS_DECIDE)
			send_len <= sel_len;
	end

	// ========================================================================
	// compare sweep with read data one cycle behind the address
	// ========================================================================
	assign cmp_addr = cnt - 1'b1;  // wraps high on cnt == 0
	assign in1      = cmp_addr < rpt_q.len1;
	assign in2      = cmp_addr < rpt_q.len2;
	assign in3      = cmp_addr < rpt_q.len3;

	// ========================================================================
	// decide
	// ========================================================================
	always_comb begin
		verdict  = tmr_pkg::V_REJECT;
		sel_next = tmr_pkg::COPY_NONE;
		if (a12 && a13 && a23) begin
			verdict  = tmr_pkg::V_ALL_AGREE;
			sel_next = tmr_pkg::COPY_1;
		end else if (a12 || a13) begin
			verdict  = tmr_pkg::V_MAJORITY;
			sel_next = tmr_pkg::COPY_1;
		end else if (a23) begin
			verdict  = tmr_pkg::V_MAJORITY;
			sel_next = tmr_pkg::COPY_2;
		end else begin
			case (rpt_q.present)
				3'b001: sel_next = tmr_pkg::COPY_1;
				3'b010: sel_next = tmr_pkg::COPY_2;
				3'b100: sel_next = tmr_pkg::COPY_3;
				default: sel_next = tmr_pkg::COPY_NONE;
			endcase
			if (sel_next != tmr_pkg::COPY_NONE)
				verdict = tmr_pkg::V_SINGLE;
		end
		case (sel_next)
			tmr_pkg::COPY_1: sel_len = rpt_q.len1;
			tmr_pkg::COPY_2: sel_len = rpt_q.len2;
			tmr_pkg::COPY_3: sel_len = rpt_q.len3;
			default:         sel_len = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= tmr_pkg::VS_IDLE;
			cnt   <= '0;
			mm12  <= 1'b0;
			mm13  <= 1'b0;
			mm23  <= 1'b0;
			a12   <= 1'b0;
			a13   <= 1'b0;
			a23   <= 1'b0;
			sel   <= tmr_pkg::COPY_NONE;
		end else begin
			case (state)
				tmr_pkg::VS_IDLE: begin
					if (group_close) begin
						cnt   <= '0;
						mm12  <= 1'b0;
						mm13  <= 1'b0;
						mm23  <= 1'b0;
						state <= tmr_pkg::VS_COMPARE;
					end
				end
				tmr_pkg::VS_COMPARE: begin
					cnt <= cnt + 1'b1;
					if (in1 && in2 && rd_data1 != rd_data2)
						mm12 <= 1'b1;
					if (in1 && in3 && rd_data1 != rd_data3)
						mm13 <= 1'b1;
					if (in2 && in3 && rd_data2 != rd_data3)
						mm23 <= 1'b1;
					if (cnt == max_len + 1'b1) begin  // mismatch flags are final here
						a12   <= !mm12 && rpt_q.present[0] && rpt_q.present[1]
							&& (rpt_q.len1 == rpt_q.len2);
						a13   <= !mm13 && rpt_q.present[0] && rpt_q.present[2]
							&& (rpt_q.len1 == rpt_q.len3);
						a23   <= !mm23 && rpt_q.present[1] && rpt_q.present[2]
							&& (rpt_q.len2 == rpt_q.len3);
						state <= tmr_pkg::VS_DECIDE;
					end
				end
				tmr_pkg::VS_DECIDE: begin
					sel   <= sel_next;
					cnt   <= '0;
					state <= (sel_len != '0) ? tmr_pkg::VS_SEND : tmr_pkg::VS_IDLE;
				end
				tmr_pkg::VS_SEND: begin
					cnt <= cnt + 1'b1;
					if (cnt == send_len)
						state <= tmr_pkg::VS_IDLE;  // last byte out
				end
				default: state <= tmr_pkg::VS_IDLE;
			endcase
		end
	end

	assign busy    = (state != tmr_pkg::VS_IDLE);
	assign rd_addr = cnt[`TMR_ADDR_W-1:0];
	assign lost    = (state == tmr_pkg::VS_DECIDE) && (verdict != tmr_pkg::V_ALL_AGREE);
	assign en_out  = (state == tmr_pkg::VS_SEND) && (cnt != '0);

	always_comb begin
		case (sel)
			tmr_pkg::COPY_1: data_out = rd_data1;
			tmr_pkg::COPY_2: data_out = rd_data2;
			tmr_pkg::COPY_3: data_out = rd_data3;
			default:         data_out = '0;
		endcase
	end

endmodule

// ==== verilog/copy_buffer.sv ====
`timescale 1ns/1ns
`include "tmr_params.svh"

module copy_buffer (
	input  logic                   clk,
	copy_bus_if.buffer             wr,
	input  logic [`TMR_ADDR_W-1:0] rd_addr,
	output logic [`TMR_DATA_W-1:0] rd_data1,
	output logic [`TMR_DATA_W-1:0] rd_data2,
	output logic [`TMR_DATA_W-1:0] rd_data3
);

	// ========================================================================
	// one bank per copy, block RAM style
	// ========================================================================
	logic [`TMR_DATA_W-1:0] mem1 [`TMR_MAX_LEN];
	logic [`TMR_DATA_W-1:0] mem2 [`TMR_MAX_LEN];
	logic [`TMR_DATA_W-1:0] mem3 [`TMR_MAX_LEN];

	always_ff @(posedge clk) begin
		if (wr.we) begin
			case (wr.bank)
				tmr_pkg::COPY_1: mem1[wr.addr] <= wr.data;
				tmr_pkg::COPY_2: mem2[wr.addr] <= wr.data;
				tmr_pkg::COPY_3: mem3[wr.addr] <= wr.data;
				default: ;  // no bank selected
			endcase
		end
	end

	// registered read, all banks at the same offset
	always_ff @(posedge clk) begin
		rd_data1 <= mem1[rd_addr];
		rd_data2 <= mem2[rd_addr];
		rd_data3 <= mem3[rd_addr];
	end

endmodule

// ==== verilog/copy_capture.sv ====
`timescale 1ns/1ns
`include "tmr_params.svh"

module copy_capture (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   rx_en,
	input  logic [`TMR_DATA_W-1:0] rx_data,
	input  logic                   busy,
	copy_bus_if.capture            wr,
	output logic                   group_close,
	output tmr_pkg::group_rpt_t    group_rpt
);

	logic                        rx_en_q;
	logic [`TMR_DATA_W-1:0]      rx_data_q;
	logic [`TMR_LEN_W-1:0]       byte_cnt;   // saturates past the id byte
	logic                        skip_q;     // frame began while busy
	logic                        skip_now;
	logic                        storing;
	tmr_pkg::copy_id_e           cur_bank;
	tmr_pkg::copy_id_e           last_copy;
	tmr_pkg::copy_id_e           new_id;
	logic [2:0]                  present_q;
	logic [2:0][`TMR_LEN_W-1:0]  len_q;
	logic [`TMR_LEN_W-1:0]       wr_cnt;
	logic                        id_hit;
	logic                        id_valid;
	logic                        store_id;
	logic                        close_id;
	logic                        end_close;
	logic                        wr_en;
	logic [1:0]                  new_idx;
	logic [1:0]                  cur_idx;

	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;  // data stage for the write bus
	end

	// ========================================================================
	// id byte classification
	// ========================================================================
	assign skip_now  = (byte_cnt == '0) ? busy : skip_q;
	assign id_hit    = rx_en_q && (byte_cnt == `TMR_ID_OFFSET) && !skip_now;
	assign id_valid  = (rx_data_q[3:2] == 2'b00) && (rx_data_q[1:0] != 2'b00);
	assign new_id    = tmr_pkg::copy_id_e'(rx_data_q[1:0]);
	assign store_id  = id_hit && id_valid && (new_id > last_copy);
	assign close_id  = id_hit && id_valid && !(new_id > last_copy) && (present_q != 3'b000);
	assign end_close = storing && !rx_en_q && (cur_bank == tmr_pkg::COPY_3);

	assign new_idx = rx_data_q[1:0] - 2'd1;
	assign cur_idx = 2'(cur_bank) - 2'd1;
	assign wr_en   = storing && rx_en_q && (wr_cnt < `TMR_MAX_LEN);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_en_q   <= 1'b0;
			byte_cnt  <= '0;
			skip_q    <= 1'b0;
			storing   <= 1'b0;
			cur_bank  <= tmr_pkg::COPY_NONE;
			last_copy <= tmr_pkg::COPY_NONE;
			present_q <= 3'b000;
			len_q     <= '0;
			wr_cnt    <= '0;
		end else begin
			rx_en_q <= rx_en;
			if (!rx_en_q) begin
				byte_cnt <= '0;
				skip_q   <= 1'b0;
				storing  <= 1'b0;  // frame over
			end else begin
				skip_q <= skip_now;
				if (byte_cnt <= `TMR_ID_OFFSET)
					byte_cnt <= byte_cnt + 1'b1;
			end
			if (store_id) begin
				storing            <= 1'b1;
				cur_bank           <= new_id;
				last_copy          <= new_id;
				present_q[new_idx] <= 1'b1;
				len_q[new_idx]     <= '0;  // empty payload is legal
				wr_cnt             <= '0;
			end
			if (wr_en) begin
				wr_cnt         <= wr_cnt + 1'b1;
				len_q[cur_idx] <= wr_cnt + 1'b1;
			end
			if (group_close) begin
				present_q <= 3'b000;  // open a fresh group
				last_copy <= tmr_pkg::COPY_NONE;
				len_q     <= '0;
			end
		end
	end

	assign wr.we   = wr_en;
	assign wr.bank = cur_bank;
	assign wr.addr = wr_cnt[`TMR_ADDR_W-1:0];
	assign wr.data = rx_data_q;

	assign group_close = close_id || end_close;
	assign group_rpt   = '{present: present_q, len1: len_q[0], len2: len_q[1], len3: len_q[2]};

endmodule

// ==== verilog/copy_bus_if.sv ====
`timescale 1ns/1ns
`include "tmr_params.svh"

interface copy_bus_if;

	logic                   we;    // one write per cycle
	tmr_pkg::copy_id_e      bank;  // target copy bank
	logic [`TMR_ADDR_W-1:0] addr;  // payload offset
	logic [`TMR_DATA_W-1:0] data;

	modport capture (
		output we,
		output bank,
		output addr,
		output data
	);

	modport buffer (
		input we,
		input bank,
		input addr,
		input data
	);

endinterface

// ==== verilog/tmr_pkg.sv ====
`include "tmr_params.svh"

package tmr_pkg;

	// copy number carried in the id byte
	typedef enum logic [1:0] {
		COPY_NONE = 2'd0,
		COPY_1    = 2'd1,
		COPY_2    = 2'd2,
		COPY_3    = 2'd3
	} copy_id_e;

	// vote/sender controller
	typedef enum logic [1:0] {
		VS_IDLE    = 2'd0,
		VS_COMPARE = 2'd1,
		VS_DECIDE  = 2'd2,
		VS_SEND    = 2'd3
	} vote_state_e;

	typedef enum logic [2:0] {
		V_ALL_AGREE = 3'd0,  // three copies, all equal
		V_MAJORITY  = 3'd1,  // at least one agreeing pair
		V_SINGLE    = 3'd2,  // only one copy arrived
		V_REJECT    = 3'd3   // nothing to trust
	} verdict_e;

	typedef struct packed {
		logic [2:0]            present;  // bit i set for copy i+1
		logic [`TMR_LEN_W-1:0] len1;
		logic [`TMR_LEN_W-1:0] len2;
		logic [`TMR_LEN_W-1:0] len3;
	} group_rpt_t;

endpackage

// ==== verilog/tmr_params.svh ====
`ifndef TMR_PARAMS_SVH
`define TMR_PARAMS_SVH

// ===========================================================================
// frame layout
// ===========================================================================

`define TMR_ID_OFFSET 2     // byte index of the copy number inside a frame
`define TMR_MAX_LEN   256   // payload bytes per copy

// ===========================================================================
// widths
// ===========================================================================

`define TMR_ADDR_W 8        // payload address
`define TMR_DATA_W 8        // one byte
`define TMR_LEN_W  9        // holds 0..TMR_MAX_LEN

`endif
